/* filelist.f */
verilog/link_cfg_pkg.sv
verilog/link_types_pkg.sv
verilog/link_piso.sv
verilog/link_source_sync_upstream.sv
verilog/link_oddr_phy.sv
verilog/link_ddr_upstream.sv
verification/link_far_end_model.sv
verification/link_ddr_upstream_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and judges the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
  -f filelist.f \
  --top-module link_ddr_upstream_tb \
  -o link_ddr_upstream_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/link_ddr_upstream_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Regression failed" "$LOG"; then
  exit 1
fi

if ! grep -q "Regression passed" "$LOG"; then
  echo "Simulation ended without a result line"
  exit 1
fi

exit 0

/* verification/link_ddr_upstream_tb.sv */
////////////////////////////////////////////////////////////
// Drives random words into the DDR link transmitter and
// checks each lane against a queue of expected flits
////////////////////////////////////////////////////////////

module link_ddr_upstream_tb;

  localparam int nch = link_cfg_pkg::num_channel;
  localparam int n_random = 150;
  localparam int n_hold = 12;
  localparam int n_enable = 3;
  localparam int n_stall = 150;
  localparam int words_total = n_random + n_hold + n_enable + n_stall;
  localparam int cycle_limit = 20 * words_total + 500;

  logic clk_i = 1'b0;
  logic clk_2x_i = 1'b1;
  logic reset_i;
  logic link_enable_i;
  link_types_pkg::core_word_t core_data_i;
  logic valid_i;
  logic ready_o;
  logic [nch-1:0] io_clk_r_o;
  link_types_pkg::pin_half_t [nch-1:0] io_data_r_o;
  logic [nch-1:0] io_valid_r_o;
  logic [nch-1:0] io_token_i;

  logic [nch-1:0] hold;
  logic [nch-1:0] stall;
  logic stall_en;
  link_types_pkg::flit_t rx_flit [nch];
  int model_rx [nch];

  link_types_pkg::flit_t exp_q [nch][$];
  int rx_cnt [nch];
  int acc_cnt = 0;
  int cycle = 0;
  int errors = 0;
  int tests_ok = 0;
  int tests_bad = 0;
  int seed = 32'h1396f437;
  int stall_word;
  int err0;
  int acc0;
  int rx0 [nch];

  // Both clocks rise together at every clk_i edge
  always #4 clk_i = ~clk_i;
  always #2 clk_2x_i = ~clk_2x_i;

  link_ddr_upstream DUT (
    .clk_i         (clk_i),
    .clk_2x_i      (clk_2x_i),
    .reset_i       (reset_i),
    .link_enable_i (link_enable_i),
    .core_data_i   (core_data_i),
    .valid_i       (valid_i),
    .ready_o       (ready_o),
    .io_clk_r_o    (io_clk_r_o),
    .io_data_r_o   (io_data_r_o),
    .io_valid_r_o  (io_valid_r_o),
    .io_token_i    (io_token_i)
  );

  for (genvar i = 0; i < nch; i++) begin : far
    link_far_end_model model (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .io_clk_i   (io_clk_r_o[i]),
      .io_data_i  (io_data_r_o[i]),
      .io_valid_i (io_valid_r_o[i]),
      .hold_i     (hold[i]),
      .stall_i    (stall[i]),
      .token_o    (io_token_i[i]),
      .flit_o     (rx_flit[i]),
      .rx_count_o (model_rx[i])
    );
  end

  // Beat b of each accepted word goes to channel c as lane 2b+c
  always @(posedge clk_i) begin
    if (!reset_i && valid_i && ready_o) begin
      acc_cnt++;
      for (int b = 0; b < link_cfg_pkg::posi_ratio; b++) begin
        for (int c = 0; c < nch; c++) begin
          exp_q[c].push_back(core_data_i[(b * nch + c) * link_cfg_pkg::ddr_width +:
                                         link_cfg_pkg::ddr_width]);
        end
      end
    end
  end

  // Compare each flit the far end rebuilds with the queue
  always @(posedge clk_i) begin
    for (int c = 0; c < nch; c++) begin
      if (model_rx[c] != rx_cnt[c]) begin
        rx_cnt[c]++;
        assert (exp_q[c].size() != 0) else begin
          $display("Channel %0d received a flit at %0t with nothing queued", c, $time);
          errors++;
        end
        if (exp_q[c].size() != 0) begin
          assert (rx_flit[c] == exp_q[c][0]) else begin
            $display("FAILED at %0t: io_data_r_o[%0d] got %h expected %h",
                     $time, c, rx_flit[c], exp_q[c][0]);
            errors++;
          end
          void'(exp_q[c].pop_front());
        end
      end
    end
  end

  always @(posedge clk_i) begin
    #2;
    stall_word = $random(seed);
    stall = stall_en ? stall_word[nch-1:0] : '0;
  end

  always @(posedge clk_i) begin
    cycle++;
    if (cycle >= cycle_limit) begin
      $display("Run stopped by timeout after %0d cycles", cycle);
      $display("Regression failed");
      $finish;
    end
  end

  task automatic send_words(input int n, input bit rand_valid);
    int sent;
    int r;
    sent = 0;
    while (sent < n) begin
      @(posedge clk_i);
      if (valid_i && ready_o) begin
        sent++;
      end
      #1;
      r = $random(seed);
      if (sent < n) begin
        valid_i = rand_valid ? r[0] : 1'b1;
        core_data_i = {$random(seed), $random(seed)};
      end else begin
        valid_i = 1'b0;
      end
    end
  endtask

  // Waits for all queued flits, then for the last tokens to come back
  task automatic wait_drain();
    while (exp_q[0].size() != 0 || exp_q[1].size() != 0) begin
      @(posedge clk_i);
    end
    repeat (12) @(posedge clk_i);
  endtask

  task automatic mark_start();
    err0 = errors;
    acc0 = acc_cnt;
    for (int c = 0; c < nch; c++) begin
      rx0[c] = rx_cnt[c];
    end
  endtask

  task automatic report_test(input string name);
    if (errors == err0) begin
      tests_ok++;
      $display("Test %s: ok", name);
    end else begin
      tests_bad++;
      $display("Test %s: %0d errors", name, errors - err0);
    end
  endtask

  initial begin
    reset_i = 1'b1;
    link_enable_i = 1'b1;
    valid_i = 1'b0;
    core_data_i = '0;
    hold = '0;
    stall_en = 1'b0;
    for (int c = 0; c < nch; c++) begin
      rx_cnt[c] = 0;
    end

    // Outputs quiet in reset and ready right after
    mark_start();
    repeat (8) @(posedge clk_i);
    assert (io_valid_r_o == '0) else begin
      $display("FAILED at %0t: io_valid_r_o got %b expected 0", $time, io_valid_r_o);
      errors++;
    end
    assert (io_clk_r_o == '0) else begin
      $display("FAILED at %0t: io_clk_r_o got %b expected 0", $time, io_clk_r_o);
      errors++;
    end
    assert (io_data_r_o == '0) else begin
      $display("FAILED at %0t: io_data_r_o got %h expected 0", $time, io_data_r_o);
      errors++;
    end
    #1 reset_i = 1'b0;
    @(posedge clk_i);
    assert (ready_o == 1'b1) else begin
      $display("FAILED at %0t: ready_o got %b expected 1", $time, ready_o);
      errors++;
    end
    report_test("reset");

    mark_start();
    send_words(n_random, 1'b1);
    wait_drain();
    report_test("random traffic");

    // Receiver holds every flit so credits run out
    mark_start();
    #1 hold = '1;
    fork
      send_words(n_hold, 1'b0);
      begin
        while (rx_cnt[0] - rx0[0] < 16 || rx_cnt[1] - rx0[1] < 16) begin
          @(posedge clk_i);
        end
        repeat (30) begin
          @(posedge clk_i);
          assert (ready_o == 1'b0) else begin
            $display("FAILED at %0t: ready_o got %b expected 0", $time, ready_o);
            errors++;
          end
        end
        for (int c = 0; c < nch; c++) begin
          assert (rx_cnt[c] - rx0[c] == 16) else begin
            $display("Channel %0d sent %0d flits without credit", c, rx_cnt[c] - rx0[c]);
            errors++;
          end
        end
        #1 hold = '0;
      end
    join
    wait_drain();
    report_test("credit exhaustion");

    // Disabled link holds one word and sends nothing
    mark_start();
    #1 link_enable_i = 1'b0;
    fork
      send_words(n_enable, 1'b0);
      begin
        // Forwarded clock keeps running while the link is idle
        repeat (30) begin
          @(negedge clk_i);
          assert (io_clk_r_o == '1) else begin
            $display("FAILED at %0t: io_clk_r_o got %b expected %b",
                     $time, io_clk_r_o, {nch{1'b1}});
            errors++;
          end
          @(posedge clk_i);
          assert (io_clk_r_o == '0) else begin
            $display("FAILED at %0t: io_clk_r_o got %b expected 0", $time, io_clk_r_o);
            errors++;
          end
        end
        assert (acc_cnt - acc0 == 1) else begin
          $display("Link disabled but %0d words were accepted", acc_cnt - acc0);
          errors++;
        end
        for (int c = 0; c < nch; c++) begin
          assert (rx_cnt[c] == rx0[c]) else begin
            $display("Channel %0d sent flits while the link was disabled", c);
            errors++;
          end
        end
        #1 link_enable_i = 1'b1;
      end
    join
    wait_drain();
    report_test("link enable");

    // Random stalls in the receiver delay frees and tokens
    mark_start();
    stall_en = 1'b1;
    send_words(n_stall, 1'b1);
    wait_drain();
    stall_en = 1'b0;
    for (int c = 0; c < nch; c++) begin
      assert (rx_cnt[c] - rx0[c] == 2 * (acc_cnt - acc0)) else begin
        $display("Channel %0d received %0d flits for %0d words",
                 c, rx_cnt[c] - rx0[c], acc_cnt - acc0);
        errors++;
      end
    end
    report_test("receiver stalls");

    $display("Tests: %0d ok, %0d with errors, %0d errors in all", tests_ok, tests_bad, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

/* verification/link_far_end_model.sv */
////////////////////////////////////////////////////////////
// Behavioral receiver for one channel of the DDR link
// Rebuilds flits from the pins and returns credit tokens
////////////////////////////////////////////////////////////

module link_far_end_model (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        io_clk_i,
  input  link_types_pkg::pin_half_t   io_data_i,
  input  logic                        io_valid_i,
  input  logic                        hold_i,
  input  logic                        stall_i,
  output logic                        token_o,
  output link_types_pkg::flit_t       flit_o,
  output int                          rx_count_o
);

  link_types_pkg::pin_half_t low_r;
  link_types_pkg::flit_t     flit_r;

  // Flits rebuilt and flits freed so far
  int rx_total = 0;
  int freed_r;

  logic [link_cfg_pkg::lg_token_decimation-1:0] batch_r;

  assign flit_o     = flit_r;
  assign rx_count_o = rx_total;

  // Rising edge centers the low half
  always @(posedge io_clk_i) begin
    if (io_valid_i) begin
      low_r <= io_data_i;
    end
  end

  // Falling edge centers the high half and completes the flit
  always @(negedge io_clk_i) begin
    if (io_valid_i) begin
      flit_r   <= {io_data_i, low_r};
      rx_total <= rx_total + 1;
    end
  end

  // Frees at most one buffered flit per cycle
  // A full batch of frees flips the token line
  always @(posedge clk_i) begin
    if (reset_i) begin
      freed_r <= 0;
      batch_r <= '0;
      token_o <= 1'b0;
    end else if (!hold_i && !stall_i && (freed_r < rx_total)) begin
      freed_r <= freed_r + 1;
      batch_r <= batch_r + 1'b1;
      if (batch_r == '1) begin
        token_o <= ~token_o;
      end
    end
  end

endmodule

/* verilog/link_ddr_upstream.sv */
////////////////////////////////////////////////////////////
// DDR link transmitter top, core words in and channel pins out
// Serializer feeds per-channel credit senders and DDR stages
////////////////////////////////////////////////////////////

module link_ddr_upstream (
  input  logic                       clk_i,
  input  logic                       clk_2x_i,
  input  logic                       reset_i,
  input  logic                       link_enable_i,

  input  link_types_pkg::core_word_t core_data_i,
  input  logic                       valid_i,
  output logic                       ready_o,

  output logic [link_cfg_pkg::num_channel-1:0]                        io_clk_r_o,
  output link_types_pkg::pin_half_t [link_cfg_pkg::num_channel-1:0] io_data_r_o,
  output logic [link_cfg_pkg::num_channel-1:0]                        io_valid_r_o,
  input  logic [link_cfg_pkg::num_channel-1:0]                        io_token_i
);

  link_types_pkg::beat_s                 beat;
  logic                                  beat_valid;
  logic [link_cfg_pkg::num_channel-1:0] ch_ready;
  logic                                  yumi;

  // All channels take a beat together or none does
  assign yumi = (&ch_ready) & beat_valid;

  link_piso piso (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .valid_i      (valid_i),
    .core_data_i  (core_data_i),
    .ready_o      (ready_o),
    .beat_valid_o (beat_valid),
    .beat_o       (beat),
    .yumi_i       (yumi)
  );

  for (genvar i = 0; i < link_cfg_pkg::num_channel; i++) begin : ch

    link_types_pkg::flit_t io_data;
    logic                  io_valid;

    link_source_sync_upstream sso (
      .clk_i         (clk_i),
      .reset_i       (reset_i),
      .link_enable_i (link_enable_i),
      .core_data_i   (beat.lane[i]),
      .core_valid_i  (yumi),
      .core_ready_o  (ch_ready[i]),
      .io_data_o     (io_data),
      .io_valid_o    (io_valid),
      .token_i       (io_token_i[i])
    );

    // Data pins, forwarded clock taken from the valid stage
    link_oddr_phy #(.width_p(link_cfg_pkg::channel_width)) oddr_data (
      .clk_2x_i (clk_2x_i),
      .reset_i  (reset_i),
      .data_i   (io_data),
      .data_r_o (io_data_r_o[i]),
      .clk_r_o  ()
    );

    // Valid on both halves, plus the forwarded clock
    link_oddr_phy #(.width_p(1)) oddr_valid_clk (
      .clk_2x_i (clk_2x_i),
      .reset_i  (reset_i),
      .data_i   ({2{io_valid}}),
      .data_r_o (io_valid_r_o[i]),
      .clk_r_o  (io_clk_r_o[i])
    );

  end

endmodule

/* verilog/link_oddr_phy.sv */
////////////////////////////////////////////////////////////
// DDR output stage with a center-aligned forwarded clock
////////////////////////////////////////////////////////////

module link_oddr_phy #(
  parameter int width_p = 8
) (
  input  logic                   clk_2x_i,
  input  logic                   reset_i,
  input  logic [1:0][width_p-1:0] data_i,
  output logic [width_p-1:0]     data_r_o,
  output logic                   clk_r_o
);

  // High while the low half is on the pins
  // reset_i is launched from clk_i, so the last edge in reset is clk_i aligned
  logic               hi_phase_r;
  logic [width_p-1:0] high_r;

  always_ff @(posedge clk_2x_i) begin
    if (reset_i) begin
      hi_phase_r <= 1'b1;
      data_r_o   <= '0;
    end else if (!hi_phase_r) begin
      // Edge aligned with clk_i
      hi_phase_r <= 1'b1;
      data_r_o   <= data_i[0];
    end else begin
      hi_phase_r <= 1'b0;
      data_r_o   <= high_r;
    end
  end

  // Input changes at the clk_i edge, so keep the high half for later
  always_ff @(posedge clk_2x_i) begin
    if (!hi_phase_r) begin
      high_r <= data_i[1];
    end
  end

  // Half a clk_2x_i period later, lands in the middle of each half
  always_ff @(negedge clk_2x_i) begin
    if (reset_i) begin
      clk_r_o <= 1'b0;
    end else begin
      clk_r_o <= hi_phase_r;
    end
  end

endmodule

/* verilog/link_source_sync_upstream.sv */
////////////////////////////////////////////////////////////
// Per-channel sender with credit flow control
// Registers each flit toward the DDR stage when credit allows
////////////////////////////////////////////////////////////

module link_source_sync_upstream (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  link_enable_i,
  input  link_types_pkg::flit_t core_data_i,
  input  logic                  core_valid_i,
  output logic                  core_ready_o,
  output link_types_pkg::flit_t io_data_o,
  output logic                  io_valid_o,
  input  logic                  token_i
);

  // Token line comes from the receiver, unrelated to clk_i
  logic [1:0] token_sync_r;
  logic       token_prev_r;
  logic       token_edge;

  link_types_pkg::credit_cnt_t credit_r;
  link_types_pkg::credit_cnt_t credit_n;

  logic send;

  // Token synchronizer
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      token_sync_r <= '0;
      token_prev_r <= 1'b0;
    end else begin
      token_sync_r <= {token_sync_r[0], token_i};
      token_prev_r <= token_sync_r[1];
    end
  end

  // Either edge of the token returns a batch of credits
  assign token_edge = token_sync_r[1] ^ token_prev_r;

  // Sending needs an enabled link and at least one credit
  assign core_ready_o = link_enable_i & (credit_r != '0);
  assign send         = core_valid_i & core_ready_o;

  // Take one for the flit leaving, add a batch for a token edge
  always_comb begin
    credit_n = credit_r;
    if (send) begin
      credit_n = credit_n - link_types_pkg::credit_cnt_t'(1);
    end
    if (token_edge) begin
      credit_n = credit_n + link_types_pkg::credit_cnt_t'(link_cfg_pkg::token_credits);
    end
    // Never more credits than the receiver can buffer
    if (credit_n > link_types_pkg::credit_cnt_t'(link_cfg_pkg::credit_depth)) begin
      credit_n = link_types_pkg::credit_cnt_t'(link_cfg_pkg::credit_depth);
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      credit_r <= link_types_pkg::credit_cnt_t'(link_cfg_pkg::credit_depth);
    end else begin
      credit_r <= credit_n;
    end
  end

  // Valid is high for exactly one cycle per flit sent
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      io_valid_o <= 1'b0;
    end else begin
      io_valid_o <= send;
    end
  end

  // Flit stays put between sends, valid marks the new ones
  always_ff @(posedge clk_i) begin
    if (send) begin
      io_data_o <= core_data_i;
    end
  end

endmodule

/* verilog/link_piso.sv */
////////////////////////////////////////////////////////////
// Splits each core word into beats, low beat first
// One word in flight at a time keeps words in order
////////////////////////////////////////////////////////////

module link_piso (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       valid_i,
  input  link_types_pkg::core_word_t core_data_i,
  output logic                       ready_o,
  output logic                       beat_valid_o,
  output link_types_pkg::beat_s      beat_o,
  input  logic                       yumi_i
);

  link_types_pkg::piso_state_e state_r;
  link_types_pkg::piso_state_e state_n;
  link_types_pkg::core_word_t  word_r;

  // Same storage viewed as consecutive beats
  link_types_pkg::beat_s [link_cfg_pkg::posi_ratio-1:0] word_beats;

  logic accept;

  assign ready_o      = (state_r == link_types_pkg::empty);
  assign accept       = valid_i & ready_o;
  assign beat_valid_o = (state_r != link_types_pkg::empty);
  assign word_beats   = word_r;

  // High beat only once the low beat has been taken
  assign beat_o = (state_r == link_types_pkg::last) ? word_beats[1] : word_beats[0];

  always_comb begin
    state_n = state_r;
    case (state_r)
      link_types_pkg::empty: begin
        if (accept) begin
          state_n = link_types_pkg::first;
        end
      end
      link_types_pkg::first: begin
        if (yumi_i) begin
          state_n = link_types_pkg::last;
        end
      end
      link_types_pkg::last: begin
        if (yumi_i) begin
          state_n = link_types_pkg::empty;
        end
      end
      default: begin
        state_n = link_types_pkg::empty;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= link_types_pkg::empty;
    end else begin
      state_r <= state_n;
    end
  end

  // Word holds until the last beat leaves
  always_ff @(posedge clk_i) begin
    if (accept) begin
      word_r <= core_data_i;
    end
  end

endmodule

/* verilog/link_types_pkg.sv */
////////////////////////////////////////////////////////////
// Data types passed between the blocks of the link transmitter
////////////////////////////////////////////////////////////

package link_types_pkg;

  // Word as presented by the core
  typedef logic [link_cfg_pkg::core_width-1:0] core_word_t;

  // One channel's share of a beat
  typedef logic [link_cfg_pkg::ddr_width-1:0] flit_t;

  // What one channel drives on its pins per edge
  typedef logic [link_cfg_pkg::channel_width-1:0] pin_half_t;

  // Holds 0 up to the full credit depth inclusive
  typedef logic [link_cfg_pkg::lg_credit_depth:0] credit_cnt_t;

  // One beat across all channels
  // Lane 0 occupies the least significant bits
  typedef struct packed {
    flit_t [link_cfg_pkg::num_channel-1:0] lane;
  } beat_s;

  // Serializer states
  // first presents the low beat, last presents the high beat
  typedef enum logic [1:0] {
    empty = 2'd0,
    first = 2'd1,
    last  = 2'd2
  } piso_state_e;

endpackage

/* verilog/link_cfg_pkg.sv */
////////////////////////////////////////////////////////////
// Link geometry and flow control constants
// Every size in the link derives from the values below
////////////////////////////////////////////////////////////

package link_cfg_pkg;

  // Pins per data channel, one half flit per clock edge
  localparam int channel_width = 8;

  // Independent channels, each with its own forwarded clock
  localparam int num_channel = 2;

  // A flit is both edges of one clock cycle
  localparam int ddr_width = 2 * channel_width;

  // Core side word width
  localparam int core_width = 64;

  // Beats needed to move one core word across all channels
  localparam int posi_ratio = core_width / (ddr_width * num_channel);

  // Receiver buffer depth, as a log2
  localparam int lg_credit_depth = 4;
  localparam int credit_depth = 1 << lg_credit_depth;

  // Credits returned for each toggle of a token line, as a log2
  localparam int lg_token_decimation = 2;
  localparam int token_credits = 1 << lg_token_decimation;

endpackage
